// ==== verilog/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Number of translated requests that can wait for the bus.
`define REQ_FIFO_DEPTH 4

// Cycles the internal reset stays low once the external reset is released.
`define RESET_STRETCH_CYCLES 16

// kuseg accesses land this far up in the physical map.
`define KUSEG_OFFSET 32'h4000_0000

`endif

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;

    // One enable bit per byte of a word.
    typedef logic [3:0] byte_sel_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_BUSY = 1'b1
    } wb_state_t;

endpackage

`default_nettype wire

// ==== verilog/reset_stretch.sv ====
`default_nettype none

`include "mem_params.svh"

module reset_stretch (
    input  logic aclk,
    input  logic aresetn,
    output logic core_resetn
);

    localparam int CNT_W = $clog2(`RESET_STRETCH_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    // The count starts on the first edge that sees aresetn high, so the
    // core comes out of reset exactly RESET_STRETCH_CYCLES edges later.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cnt         <= '0;
            core_resetn <= 1'b0;
        end else if (!core_resetn) begin
            if (cnt == CNT_W'(`RESET_STRETCH_CYCLES)) begin
                core_resetn <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // The core leaves reset only once aresetn has been high for the whole stretch.
    a_stretch_length : assert property (
        @(posedge aclk) $rose(core_resetn) |-> $past(aresetn, `RESET_STRETCH_CYCLES + 1)
    );

endmodule

`default_nettype wire

// ==== verilog/addr_translate.sv ====
`default_nettype none

`include "mem_params.svh"

module addr_translate
    import mem_pkg::*;
(
    input  logic         aclk,
    input  logic         core_resetn,

    input  logic         req_valid,
    input  logic         req_write,
    input  access_size_t req_size,
    input  logic         req_user,
    input  word_t        req_vaddr,
    input  word_t        req_wdata,
    output logic         req_ready,

    input  logic         fifo_ready,
    output logic         push,
    output logic         push_write,
    output word_t        push_addr,
    output word_t        push_data,
    output byte_sel_t    push_sel,

    output logic         addr_error,
    output word_t        err_vaddr
);

    logic  accept;
    logic  bad_access;
    word_t paddr;

    // Nothing is taken while the core is still held in reset.
    assign req_ready = fifo_ready & core_resetn;
    assign accept    = req_valid & req_ready;

    // Fixed MIPS segment map; kseg0 and kseg1 alias the low 512 MB.
    always_comb begin
        if (!req_vaddr[31]) begin
            paddr = req_vaddr + `KUSEG_OFFSET;
        end else if (req_vaddr[30] == 1'b0) begin
            paddr = {3'b000, req_vaddr[28:0]};
        end else begin
            paddr = req_vaddr;
        end
    end

    always_comb begin
        case (req_size)
            SIZE_BYTE: push_sel = byte_sel_t'(4'b0001 << req_vaddr[1:0]);
            SIZE_HALF: push_sel = req_vaddr[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: push_sel = 4'b1111;
            default:   push_sel = 4'b0000;
        endcase
    end

    // User mode may not touch the upper half, and halves and words must be aligned.
    assign bad_access = (req_user && req_vaddr[31])
                      || (req_size == SIZE_HALF && req_vaddr[0])
                      || (req_size == SIZE_WORD && req_vaddr[1:0] != 2'b00);

    assign push       = accept & ~bad_access;
    assign push_write = req_write;
    assign push_addr  = {paddr[31:2], 2'b00};
    assign push_data  = req_wdata << {req_vaddr[1:0], 3'b000};

    always_ff @(posedge aclk) begin
        if (!core_resetn) begin
            addr_error <= 1'b0;
        end else begin
            addr_error <= accept & bad_access;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && bad_access) begin
            err_vaddr <= req_vaddr;
        end
    end

    // A request must name one of the three access sizes.
    a_size_known : assert property (
        @(posedge aclk) disable iff (!core_resetn)
        req_valid |-> (req_size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD})
    );

endmodule

`default_nettype wire

// ==== verilog/req_fifo.sv ====
`default_nettype none

module req_fifo
    import mem_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic      aclk,
    input  logic      core_resetn,

    input  logic      push,
    input  logic      push_write,
    input  word_t     push_addr,
    input  word_t     push_data,
    input  byte_sel_t push_sel,
    output logic      fifo_ready,

    input  logic      pop,
    output logic      pop_valid,
    output logic      pop_write,
    output word_t     pop_addr,
    output word_t     pop_data,
    output byte_sel_t pop_sel
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic      mem_write [DEPTH];
    word_t     mem_addr  [DEPTH];
    word_t     mem_data  [DEPTH];
    byte_sel_t mem_sel   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full       = (count == CNT_W'(DEPTH));
    assign fifo_ready = ~full;
    assign pop_valid  = (count != '0);

    // The head is read straight from storage, so a full FIFO can take a
    // new entry into the slot that is popped in the same cycle.
    assign pop_write = mem_write[rd_ptr];
    assign pop_addr  = mem_addr[rd_ptr];
    assign pop_data  = mem_data[rd_ptr];
    assign pop_sel   = mem_sel[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_write[wr_ptr] <= push_write;
            mem_addr[wr_ptr]  <= push_addr;
            mem_data[wr_ptr]  <= push_data;
            mem_sel[wr_ptr]   <= push_sel;
        end
    end

    always_ff @(posedge aclk) begin
        if (!core_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow : assert property (
        @(posedge aclk) disable iff (!core_resetn)
        (push && full) |-> pop
    );

    a_no_underflow : assert property (
        @(posedge aclk) disable iff (!core_resetn)
        pop |-> pop_valid
    );

endmodule

`default_nettype wire

// ==== verilog/wb_master.sv ====
`default_nettype none

module wb_master
    import mem_pkg::*;
(
    input  logic      aclk,
    input  logic      core_resetn,

    input  logic      pop_valid,
    input  logic      pop_write,
    input  word_t     pop_addr,
    input  word_t     pop_data,
    input  byte_sel_t pop_sel,
    output logic      pop,

    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output word_t     wb_adr,
    output word_t     wb_dat_w,
    output byte_sel_t wb_sel,
    input  word_t     wb_dat_r,
    input  logic      wb_ack,

    output logic      rsp_valid,
    output word_t     rsp_rdata
);

    wb_state_t state;

    // One classic transfer per bus cycle, so cyc and stb move together.
    assign wb_cyc = (state == WB_BUSY);
    assign wb_stb = (state == WB_BUSY);
    assign pop    = (state == WB_IDLE) && pop_valid;

    always_ff @(posedge aclk) begin
        if (!core_resetn) begin
            state     <= WB_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                WB_IDLE: begin
                    if (pop_valid) begin
                        state <= WB_BUSY;
                    end
                end
                WB_BUSY: begin
                    if (wb_ack) begin
                        state     <= WB_IDLE;
                        rsp_valid <= ~wb_we;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Request fields are captured as the entry leaves the FIFO.
    always_ff @(posedge aclk) begin
        if (pop) begin
            wb_we    <= pop_write;
            wb_adr   <= pop_addr;
            wb_dat_w <= pop_data;
            wb_sel   <= pop_sel;
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_stb && wb_ack && !wb_we) begin
            rsp_rdata <= wb_dat_r;
        end
    end

    a_bus_stable : assert property (
        @(posedge aclk) disable iff (!core_resetn)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable({wb_we, wb_adr, wb_dat_w, wb_sel}))
    );

endmodule

`default_nettype wire

// ==== verilog/mem_access_top.sv ====
`default_nettype none

`include "mem_params.svh"

module mem_access_top
    import mem_pkg::*;
(
    input  logic         aclk,
    input  logic         aresetn,

    input  logic         req_valid,
    input  logic         req_write,
    input  access_size_t req_size,
    input  logic         req_user,
    input  word_t        req_vaddr,
    input  word_t        req_wdata,
    output logic         req_ready,

    output logic         addr_error,
    output word_t        err_vaddr,

    output logic         rsp_valid,
    output word_t        rsp_rdata,

    output logic         wb_cyc,
    output logic         wb_stb,
    output logic         wb_we,
    output word_t        wb_adr,
    output word_t        wb_dat_w,
    output byte_sel_t    wb_sel,
    input  word_t        wb_dat_r,
    input  logic         wb_ack
);

    logic      core_resetn;

    logic      push;
    logic      push_write;
    word_t     push_addr;
    word_t     push_data;
    byte_sel_t push_sel;
    logic      fifo_ready;

    logic      pop;
    logic      pop_valid;
    logic      pop_write;
    word_t     pop_addr;
    word_t     pop_data;
    byte_sel_t pop_sel;

    reset_stretch i_reset_stretch (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .core_resetn (core_resetn)
    );

    addr_translate i_addr_translate (
        .aclk        (aclk),
        .core_resetn (core_resetn),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_size    (req_size),
        .req_user    (req_user),
        .req_vaddr   (req_vaddr),
        .req_wdata   (req_wdata),
        .req_ready   (req_ready),
        .fifo_ready  (fifo_ready),
        .push        (push),
        .push_write  (push_write),
        .push_addr   (push_addr),
        .push_data   (push_data),
        .push_sel    (push_sel),
        .addr_error  (addr_error),
        .err_vaddr   (err_vaddr)
    );

    req_fifo #(
        .DEPTH (`REQ_FIFO_DEPTH)
    ) i_req_fifo (
        .aclk        (aclk),
        .core_resetn (core_resetn),
        .push        (push),
        .push_write  (push_write),
        .push_addr   (push_addr),
        .push_data   (push_data),
        .push_sel    (push_sel),
        .fifo_ready  (fifo_ready),
        .pop         (pop),
        .pop_valid   (pop_valid),
        .pop_write   (pop_write),
        .pop_addr    (pop_addr),
        .pop_data    (pop_data),
        .pop_sel     (pop_sel)
    );

    wb_master i_wb_master (
        .aclk        (aclk),
        .core_resetn (core_resetn),
        .pop_valid   (pop_valid),
        .pop_write   (pop_write),
        .pop_addr    (pop_addr),
        .pop_data    (pop_data),
        .pop_sel     (pop_sel),
        .pop         (pop),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_access.sv ====
`default_nettype none

`include "mem_params.svh"

module tb_mem_access
    import mem_pkg::*;
();

    localparam int MAX_PATTERNS = 64;

    logic         aclk = 1'b0;
    logic         aresetn;
    logic         req_valid;
    logic         req_write;
    access_size_t req_size;
    logic         req_user;
    word_t        req_vaddr;
    word_t        req_wdata;
    logic         req_ready;
    logic         addr_error;
    word_t        err_vaddr;
    logic         rsp_valid;
    word_t        rsp_rdata;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    word_t        wb_adr;
    word_t        wb_dat_w;
    byte_sel_t    wb_sel;
    word_t        wb_dat_r;
    logic         wb_ack;

    string        pat_name  [MAX_PATTERNS];
    logic         pat_write [MAX_PATTERNS];
    logic         pat_user  [MAX_PATTERNS];
    access_size_t pat_size  [MAX_PATTERNS];
    word_t        pat_vaddr [MAX_PATTERNS];
    word_t        pat_wdata [MAX_PATTERNS];
    logic         pat_error [MAX_PATTERNS];
    word_t        pat_adr   [MAX_PATTERNS];
    byte_sel_t    pat_sel   [MAX_PATTERNS];
    word_t        pat_dat   [MAX_PATTERNS];
    int           num_patterns = 0;
    int           watchdog_cycles = 0;

    // Pattern indices whose bus cycle, load data or error pulse is still due, oldest first.
    int           exp_bus [$];
    int           exp_rsp [$];
    int           exp_err [$];

    integer       seed = 32'h9ecd;
    logic         saw_stall = 1'b0;

    always #5 aclk = ~aclk;

    mem_access_top i_mem_access_top (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_size   (req_size),
        .req_user   (req_user),
        .req_vaddr  (req_vaddr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .addr_error (addr_error),
        .err_vaddr  (err_vaddr),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_patterns();
        int    fd;
        int    fields;
        int    user;
        string line;
        string name;
        string op;
        string size;
        string result;
        word_t vaddr;
        word_t wdata;
        word_t adr;
        word_t sel;
        word_t dat;
        fd = $fopen("testbench/mem_access_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/mem_access_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            fields = $sscanf(line, "%s %s %d %s %h %h %s %h %h %h",
                             name, op, user, size, vaddr, wdata, result, adr, sel, dat);
            if (fields != 10 || num_patterns == MAX_PATTERNS) begin
                abort_run({"malformed pattern line: ", line});
            end
            pat_name[num_patterns]  = name;
            pat_write[num_patterns] = (op == "st");
            pat_user[num_patterns]  = (user != 0);
            pat_size[num_patterns]  = (size == "b") ? SIZE_BYTE :
                                      (size == "h") ? SIZE_HALF : SIZE_WORD;
            pat_vaddr[num_patterns] = vaddr;
            pat_wdata[num_patterns] = wdata;
            pat_error[num_patterns] = (result == "err");
            pat_adr[num_patterns]   = adr;
            pat_sel[num_patterns]   = sel[3:0];
            pat_dat[num_patterns]   = dat;
            num_patterns++;
        end
        $fclose(fd);
        if (num_patterns == 0) begin
            abort_run("the pattern file holds no accesses");
        end
    endtask

    // Expectations are queued before the request is offered, so they always lead the DUT.
    task automatic drive_request(input int idx);
        logic taken;
        if (pat_error[idx]) begin
            exp_err.push_back(idx);
        end else begin
            exp_bus.push_back(idx);
            if (!pat_write[idx]) begin
                exp_rsp.push_back(idx);
            end
        end
        req_valid = 1'b1;
        req_write = pat_write[idx];
        req_size  = pat_size[idx];
        req_user  = pat_user[idx];
        req_vaddr = pat_vaddr[idx];
        req_wdata = pat_wdata[idx];
        taken     = 1'b0;
        while (!taken) begin
            taken = req_ready;
            if (!req_ready) begin
                saw_stall = 1'b1;
            end
            @(posedge aclk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic match_bus_transfer();
        int idx;
        if (exp_bus.size() == 0) begin
            abort_run("a bus cycle ran with no access expected");
        end
        idx = exp_bus.pop_front();
        compare_value(pat_name[idx], "wb_we", 32'(pat_write[idx]), 32'(wb_we));
        compare_value(pat_name[idx], "wb_adr", pat_adr[idx], wb_adr);
        compare_value(pat_name[idx], "wb_sel", 32'(pat_sel[idx]), 32'(wb_sel));
        if (pat_write[idx]) begin
            compare_value(pat_name[idx], "wb_dat_w", pat_dat[idx], wb_dat_w);
        end
    endtask

    // Wishbone slave with 0 to 3 wait states; read data is the inverted bus address.
    initial begin : wb_slave
        int   waits;
        logic active;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        waits    = 0;
        active   = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            wb_ack = 1'b0;
            if (wb_cyc === 1'b1 && wb_stb === 1'b1) begin
                if (!active) begin
                    active = 1'b1;
                    waits  = $random(seed) & 3;
                end
                if (waits == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_r = ~wb_adr;
                    active   = 1'b0;
                    match_bus_transfer();
                end else begin
                    waits--;
                end
            end
        end
    end

    initial begin : output_monitor
        int idx;
        forever begin
            @(posedge aclk);
            #1;
            if (rsp_valid === 1'b1) begin
                if (exp_rsp.size() == 0) begin
                    abort_run("load data came back with no load outstanding");
                end
                idx = exp_rsp.pop_front();
                compare_value(pat_name[idx], "rsp_rdata", ~pat_adr[idx], rsp_rdata);
            end
            if (addr_error === 1'b1) begin
                if (exp_err.size() == 0) begin
                    abort_run("addr_error pulsed for an access that was legal");
                end
                idx = exp_err.pop_front();
                compare_value(pat_name[idx], "err_vaddr", pat_vaddr[idx], err_vaddr);
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge aclk);
        abort_run("timeout, the run did not finish in time");
    end

    initial begin : main_sequence
        int cycles;
        int drain;
        int i;
        aresetn   = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_size  = SIZE_BYTE;
        req_user  = 1'b0;
        req_vaddr = '0;
        req_wdata = '0;
        load_patterns();
        watchdog_cycles = 50 * num_patterns + 100;

        repeat (3) @(posedge aclk);
        #1;
        compare_value("reset", "req_ready", 32'd0, 32'(req_ready));
        compare_value("reset", "wb_cyc", 32'd0, 32'(wb_cyc));
        compare_value("reset", "rsp_valid", 32'd0, 32'(rsp_valid));
        aresetn = 1'b1;

        // The next edge is the first to see aresetn high.
        @(posedge aclk);
        #1;
        cycles = 0;
        while (req_ready !== 1'b1) begin
            compare_value("reset", "wb_cyc", 32'd0, 32'(wb_cyc));
            compare_value("reset", "rsp_valid", 32'd0, 32'(rsp_valid));
            compare_value("reset", "addr_error", 32'd0, 32'(addr_error));
            if (cycles > 4 * `RESET_STRETCH_CYCLES) begin
                abort_run("req_ready never rose after reset");
            end
            @(posedge aclk);
            #1;
            cycles++;
        end
        compare_value("reset", "req_ready delay", 32'(`RESET_STRETCH_CYCLES), 32'(cycles));

        for (i = 0; i < num_patterns; i++) begin
            drive_request(i);
        end

        drain = 0;
        while (exp_bus.size() + exp_rsp.size() + exp_err.size() != 0) begin
            if (drain == 200) begin
                abort_run("expected accesses were left over at the end");
            end
            @(posedge aclk);
            drain++;
        end
        repeat (10) @(posedge aclk);
        compare_value("backpressure", "req_ready dropped", 32'd1, 32'(saw_stall));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/mem_access_patterns.txt ====
# name op(ld/st) user size(b/h/w) vaddr wdata result(bus/err) bus_adr sel store_data
# kuseg adds 4000_0000, kseg0 and kseg1 clear bits 31 to 29, kseg2 and kseg3 pass through
t_kuseg_lo   st 0 w 00000000 11223344 bus 40000000 f 11223344
t_kuseg_mid  st 0 w 12345678 55667788 bus 52345678 f 55667788
t_kuseg_top  st 0 w 7ffffffc cafef00d bus bffffffc f cafef00d
t_kuseg_user st 1 w 00001000 0badc0de bus 40001000 f 0badc0de
t_kseg0      st 0 w 80001234 01020304 bus 00001234 f 01020304
t_kseg0_top  st 0 w 9ffffff0 a5a5a5a5 bus 1ffffff0 f a5a5a5a5
t_kseg1      st 0 w a0004000 5a5a5a5a bus 00004000 f 5a5a5a5a
t_kseg1_top  st 0 w bffffffc 0f0f0f0f bus 1ffffffc f 0f0f0f0f
t_kseg2      st 0 w c0000010 f0f0f0f0 bus c0000010 f f0f0f0f0
t_kseg3      st 0 w fffffff8 87654321 bus fffffff8 f 87654321
b_lane0      st 0 b 80000100 000000a5 bus 00000100 1 000000a5
b_lane1      st 0 b 80000101 000000a6 bus 00000100 2 0000a600
b_lane2      st 0 b 80000102 000000a7 bus 00000100 4 00a70000
b_lane3      st 0 b 80000103 000000a8 bus 00000100 8 a8000000
h_lane0      st 0 h 00000200 0000beef bus 40000200 3 0000beef
h_lane2      st 0 h 00000202 0000cafe bus 40000200 c cafe0000
b_user       st 1 b 00000305 0000005a bus 40000304 2 00005a00
e_user_kseg0 ld 1 w 80000000 00000000 err 00000000 0 00000000
e_user_kseg2 st 1 b c0000001 000000ff err 00000000 0 00000000
e_half_odd1  ld 0 h 80000001 00000000 err 00000000 0 00000000
e_half_odd3  st 0 h 00000003 0000abcd err 00000000 0 00000000
e_word_1     ld 0 w 80000005 00000000 err 00000000 0 00000000
e_word_2     st 0 w 00000002 12345678 err 00000000 0 00000000
e_word_3     ld 0 w c0000003 00000000 err 00000000 0 00000000
l_kuseg      ld 0 w 00000040 00000000 bus 40000040 f 00000000
l_kseg0      ld 0 w 80000044 00000000 bus 00000044 f 00000000
l_kseg1      ld 0 w a0000048 00000000 bus 00000048 f 00000000
l_kseg2      ld 0 w c000004c 00000000 bus c000004c f 00000000
l_byte       ld 0 b 80000051 00000000 bus 00000050 2 00000000
l_half       ld 0 h 80000056 00000000 bus 00000054 c 00000000
l_user       ld 1 w 00000060 00000000 bus 40000060 f 00000000
l_kseg3      ld 0 w e0000064 00000000 bus e0000064 f 00000000
l_mix_st     st 0 w 80000068 13579bdf bus 00000068 f 13579bdf
l_after      ld 0 w 8000006c 00000000 bus 0000006c f 00000000
l_byte0      ld 0 b 00000070 00000000 bus 40000070 1 00000000
l_half0      ld 0 h a0000074 00000000 bus 00000074 3 00000000

// ==== sources.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/reset_stretch.sv
verilog/addr_translate.sv
verilog/req_fifo.sv
verilog/wb_master.sv
verilog/mem_access_top.sv
testbench/tb_mem_access.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_mem_access

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): sources.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module tb_mem_access \
		-Mdir obj_dir -o Vtb_mem_access

clean:
	rm -rf obj_dir
